// ==== src/dds_macros.svh ====
`ifndef DDS_MACROS_SVH
`define DDS_MACROS_SVH

// datapath widths
`define DDS_PHASE_W   32
`define DDS_SAMPLE_W  12
`define DDS_LUT_AW    4     // quarter table, 16 entries
`define DDS_LFSR_W    5
`define DDS_PERIOD_W  16

// register bus
`define AXIL_ADDR_W   5
`define AXIL_DATA_W   32

`endif

// ==== src/dds_pkg.sv ====
`include "dds_macros.svh"

package dds_pkg;

   typedef logic signed [`DDS_SAMPLE_W-1:0] sample_t;
   typedef logic [`DDS_PHASE_W-1:0] phase_t;

   typedef enum logic [1:0] {
      wave_sine   = 2'd0,
      wave_cosine = 2'd1,
      wave_saw    = 2'd2,
      wave_square = 2'd3
   } wave_sel_t;

   typedef enum logic [1:0] {
      mod_ask  = 2'd0,
      mod_fsk  = 2'd1,
      mod_bpsk = 2'd2,
      mod_prbs = 2'd3
   } mod_sel_t;

   // full scale of a sample
   localparam sample_t sample_max = sample_t'(2047);
   localparam sample_t sample_min = sample_t'(-2048);

endpackage

// ==== src/axil_pkg.sv ====
`include "dds_macros.svh"

package axil_pkg;

   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_slverr = 2'b10
   } axil_resp_t;

   // byte offsets of the register map
   typedef enum logic [`AXIL_ADDR_W-1:0] {
      reg_ctrl        = 5'h00,
      reg_carrier_inc = 5'h04,
      reg_fsk_inc     = 5'h08,
      reg_bit_period  = 5'h0C,
      reg_status      = 5'h10   // read only
   } reg_addr_t;

endpackage

// ==== src/dds_ctrl_if.sv ====
`timescale 1ns/10ps
`include "dds_macros.svh"

interface dds_ctrl_if
   import dds_pkg::*;
();

   logic                     run;
   wave_sel_t                wave_sel;
   mod_sel_t                 mod_sel;
   phase_t                   carrier_inc;
   phase_t                   fsk_inc;
   logic [`DDS_PERIOD_W-1:0] bit_period;
   logic [`DDS_LFSR_W-1:0]   lfsr_state;   // back from the bit source

   modport regs (
      output run, wave_sel, mod_sel, carrier_inc, fsk_inc, bit_period,
      input  lfsr_state
   );

   modport datapath (
      input  run, wave_sel, mod_sel, carrier_inc, fsk_inc, bit_period,
      output lfsr_state
   );

endinterface

// ==== src/axil_regs.sv ====
`timescale 1ns/10ps
`include "dds_macros.svh"

module axil_regs
   import dds_pkg::*;
   import axil_pkg::*;
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic [`AXIL_ADDR_W-1:0]   awaddr,
   input  logic                      awvalid,
   output logic                      awready,
   input  logic [`AXIL_DATA_W-1:0]   wdata,
   input  logic [`AXIL_DATA_W/8-1:0] wstrb,    // full-word writes only
   input  logic                      wvalid,
   output logic                      wready,
   output axil_resp_t                bresp,
   output logic                      bvalid,
   input  logic                      bready,
   input  logic [`AXIL_ADDR_W-1:0]   araddr,
   input  logic                      arvalid,
   output logic                      arready,
   output logic [`AXIL_DATA_W-1:0]   rdata,
   output axil_resp_t                rresp,
   output logic                      rvalid,
   input  logic                      rready,
   dds_ctrl_if.regs                  ctrl
);

   logic                    wr_accept;
   logic                    rd_accept;
   logic                    wr_mapped;
   logic                    rd_mapped;
   logic [`AXIL_DATA_W-1:0] rd_word;

   // address and data taken together, one write in flight
   assign wr_accept = awvalid & wvalid & ~bvalid;
   assign rd_accept = arvalid & ~rvalid;
   assign awready   = wr_accept;
   assign wready    = wr_accept;
   assign arready   = rd_accept;

   always_comb
   begin
      case (awaddr)
         reg_ctrl, reg_carrier_inc, reg_fsk_inc, reg_bit_period, reg_status:
            wr_mapped = 1'b1;
         default:
            wr_mapped = 1'b0;
      endcase
   end

   always_comb
   begin
      rd_word   = '0;
      rd_mapped = 1'b1;
      case (araddr)
         reg_ctrl:        rd_word[4:0] = {ctrl.mod_sel, ctrl.wave_sel, ctrl.run};
         reg_carrier_inc: rd_word = ctrl.carrier_inc;
         reg_fsk_inc:     rd_word = ctrl.fsk_inc;
         reg_bit_period:  rd_word[`DDS_PERIOD_W-1:0] = ctrl.bit_period;
         reg_status:      rd_word[`DDS_LFSR_W-1:0] = ctrl.lfsr_state;
         default:         rd_mapped = 1'b0;     // reads back as zero
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // write channel and control registers
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         bvalid           <= 1'b0;
         bresp            <= resp_okay;
         ctrl.run         <= 1'b0;
         ctrl.wave_sel    <= wave_sine;
         ctrl.mod_sel     <= mod_ask;
         ctrl.carrier_inc <= '0;
         ctrl.fsk_inc     <= '0;
         ctrl.bit_period  <= `DDS_PERIOD_W'(100);
      end
      else if (wr_accept)
      begin
         bvalid <= 1'b1;
         bresp  <= wr_mapped ? resp_okay : resp_slverr;
         case (awaddr)
            reg_ctrl:
            begin
               ctrl.run      <= wdata[0];
               ctrl.wave_sel <= wave_sel_t'(wdata[2:1]);
               ctrl.mod_sel  <= mod_sel_t'(wdata[4:3]);
            end
            reg_carrier_inc: ctrl.carrier_inc <= wdata;
            reg_fsk_inc:     ctrl.fsk_inc <= wdata;
            reg_bit_period:  ctrl.bit_period <= wdata[`DDS_PERIOD_W-1:0];
            default: ;       // status or unmapped, nothing to store
         endcase
      end
      else if (bready)
         bvalid <= 1'b0;
   end

   //////////////////////////////////////////////////////////////////////
   // read channel
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rvalid <= 1'b0;
         rresp  <= resp_okay;
         rdata  <= '0;
      end
      else if (rd_accept)
      begin
         rvalid <= 1'b1;
         rresp  <= rd_mapped ? resp_okay : resp_slverr;
         rdata  <= rd_word;
      end
      else if (rready)
         rvalid <= 1'b0;
   end

endmodule

// ==== src/dds_waveform.sv ====
`timescale 1ns/10ps
`include "dds_macros.svh"

module dds_waveform
   import dds_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    run,
   input  phase_t  phase_inc,
   output sample_t sin_out,
   output sample_t cos_out,
   output sample_t saw_out,
   output sample_t squ_out
);

   localparam int lut_depth = 1 << `DDS_LUT_AW;

   logic [`DDS_SAMPLE_W-1:0] quarter_rom [0:lut_depth-1];   // first quadrant magnitudes
   phase_t                   phase;
   logic [1:0]               quad;
   logic [`DDS_LUT_AW-1:0]   idx;

   initial
   begin
      $readmemh("sine_quarter.hex", quarter_rom);
   end

   // quadrant folding of the quarter table
   function automatic sample_t fold(input logic [1:0] q, input logic [`DDS_LUT_AW-1:0] i);
      logic [`DDS_LUT_AW-1:0] addr;
      sample_t                mag;
      addr = q[0] ? ~i : i;            // mirror in quadrants 1 and 3
      mag  = $signed(quarter_rom[addr]);
      return q[1] ? -mag : mag;        // second half negative
   endfunction

   assign quad = phase[`DDS_PHASE_W-1 -: 2];
   assign idx  = phase[`DDS_PHASE_W-3 -: `DDS_LUT_AW];

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         phase   <= '0;
         sin_out <= '0;
         cos_out <= '0;
         saw_out <= '0;
         squ_out <= '0;
      end
      else
      begin
         if (run)
            phase <= phase + phase_inc;
         sin_out <= fold(quad, idx);
         cos_out <= fold(quad + 2'd1, idx);   // quarter turn ahead
         saw_out <= $signed(phase[`DDS_PHASE_W-1 -: `DDS_SAMPLE_W]);
         squ_out <= phase[`DDS_PHASE_W-1] ? -sample_max : sample_max;
      end
   end

endmodule

// ==== src/prbs_bit_source.sv ====
`timescale 1ns/10ps
`include "dds_macros.svh"

module prbs_bit_source (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     run,
   input  logic [`DDS_PERIOD_W-1:0] bit_period,
   output logic [`DDS_LFSR_W-1:0]   lfsr_state,
   output logic                     prbs_bit
);

   logic [`DDS_PERIOD_W-1:0] count;
   logic [`DDS_PERIOD_W-1:0] last_count;
   logic                     step;

   // a period of zero behaves as one
   assign last_count = (bit_period == '0) ? '0 : bit_period - 1'b1;
   assign step       = run & (count >= last_count);   // also catches a shortened period

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         count <= '0;
      else if (run)
         count <= step ? '0 : count + 1'b1;
   end

   // fibonacci, taps on bits 0 and 2
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         lfsr_state <= '1;
      else if (step)
         lfsr_state <= {lfsr_state[0] ^ lfsr_state[2], lfsr_state[`DDS_LFSR_W-1:1]};
   end

   assign prbs_bit = lfsr_state[0];

endmodule

// ==== src/modulator.sv ====
`timescale 1ns/10ps

module modulator
   import dds_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   dds_ctrl_if.datapath ctrl,
   input  sample_t      carrier_sin,
   input  sample_t      carrier_cos,
   input  sample_t      carrier_saw,
   input  sample_t      carrier_squ,
   input  sample_t      fsk_cos,
   input  logic         bit_in,
   output sample_t      wave_sample,
   output sample_t      mod_sample,
   output logic         prbs_bit
);

   logic    bit_d;       // lines up with the registered carrier
   sample_t wave_next;
   sample_t mod_next;

   always_comb
   begin
      case (ctrl.wave_sel)
         wave_sine:   wave_next = carrier_sin;
         wave_cosine: wave_next = carrier_cos;
         wave_saw:    wave_next = carrier_saw;
         default:     wave_next = carrier_squ;
      endcase
   end

   always_comb
   begin
      case (ctrl.mod_sel)
         mod_ask:  mod_next = bit_d ? carrier_cos : '0;
         mod_fsk:  mod_next = bit_d ? fsk_cos : carrier_cos;
         mod_bpsk: mod_next = bit_d ? carrier_cos : -carrier_cos;
         default:  mod_next = bit_d ? sample_max : sample_min;   // raw bit
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         bit_d       <= 1'b0;
         prbs_bit    <= 1'b0;
         wave_sample <= '0;
         mod_sample  <= '0;
      end
      else
      begin
         bit_d       <= bit_in;
         prbs_bit    <= bit_d;
         wave_sample <= wave_next;
         mod_sample  <= mod_next;
      end
   end

endmodule

// ==== src/dds_mod_top.sv ====
`timescale 1ns/10ps
`include "dds_macros.svh"

module dds_mod_top
   import dds_pkg::*;
   import axil_pkg::*;
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic [`AXIL_ADDR_W-1:0]   awaddr,
   input  logic                      awvalid,
   output logic                      awready,
   input  logic [`AXIL_DATA_W-1:0]   wdata,
   input  logic [`AXIL_DATA_W/8-1:0] wstrb,
   input  logic                      wvalid,
   output logic                      wready,
   output axil_resp_t                bresp,
   output logic                      bvalid,
   input  logic                      bready,
   input  logic [`AXIL_ADDR_W-1:0]   araddr,
   input  logic                      arvalid,
   output logic                      arready,
   output logic [`AXIL_DATA_W-1:0]   rdata,
   output axil_resp_t                rresp,
   output logic                      rvalid,
   input  logic                      rready,
   output sample_t                   wave_sample,
   output sample_t                   mod_sample,
   output logic                      prbs_bit
);

   sample_t car_sin;
   sample_t car_cos;
   sample_t car_saw;
   sample_t car_squ;
   sample_t fsk_cos;
   logic    lfsr_bit;

   dds_ctrl_if ctrl ();

   //////////////////////////////////////////////////////////////////////
   // register block
   axil_regs axil_regs_inst (
      .clk, .reset,
      .awaddr, .awvalid, .awready,
      .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready,
      .rdata, .rresp, .rvalid, .rready,
      .ctrl  (ctrl.regs)
   );

   //////////////////////////////////////////////////////////////////////
   // two carriers, the fsk core only feeds its cosine onward
   dds_waveform carrier_dds (
      .clk, .reset,
      .run       (ctrl.run),
      .phase_inc (ctrl.carrier_inc),
      .sin_out   (car_sin),
      .cos_out   (car_cos),
      .saw_out   (car_saw),
      .squ_out   (car_squ)
   );

   dds_waveform fsk_dds (
      .clk, .reset,
      .run       (ctrl.run),
      .phase_inc (ctrl.fsk_inc),
      .sin_out   (),
      .cos_out   (fsk_cos),
      .saw_out   (),
      .squ_out   ()
   );

   prbs_bit_source prbs_inst (
      .clk, .reset,
      .run        (ctrl.run),
      .bit_period (ctrl.bit_period),
      .lfsr_state (ctrl.lfsr_state),   // readable through status
      .prbs_bit   (lfsr_bit)
   );

   modulator modulator_inst (
      .clk, .reset,
      .ctrl        (ctrl.datapath),
      .carrier_sin (car_sin),
      .carrier_cos (car_cos),
      .carrier_saw (car_saw),
      .carrier_squ (car_squ),
      .fsk_cos     (fsk_cos),
      .bit_in      (lfsr_bit),
      .wave_sample,
      .mod_sample,
      .prbs_bit
   );

endmodule

// ==== testbench/tb_dds_mod.sv ====
`timescale 1ns/10ps
`include "dds_macros.svh"

module tb_dds_mod
   import dds_pkg::*;
   import axil_pkg::*;
();

   localparam int wave_len     = 500;
   localparam int prbs_rounds  = 4;
   localparam int prbs_len     = 1200;
   localparam int mod_len      = 1200;
   localparam int hold_len     = 300;
   localparam int bus_overhead = 1000;    // register traffic between the runs
   localparam int test_cycles  = 4*wave_len + prbs_rounds*prbs_len + 3*mod_len
                                 + 3*hold_len + bus_overhead;
   localparam int cycle_limit  = test_cycles * 5 / 3;
   localparam phase_t quarter_turn = 32'h4000_0000;

   logic                      clk;
   logic                      reset;
   logic [`AXIL_ADDR_W-1:0]   awaddr;
   logic                      awvalid;
   logic                      awready;
   logic [`AXIL_DATA_W-1:0]   wdata;
   logic [`AXIL_DATA_W/8-1:0] wstrb;
   logic                      wvalid;
   logic                      wready;
   axil_resp_t                bresp;
   logic                      bvalid;
   logic                      bready;
   logic [`AXIL_ADDR_W-1:0]   araddr;
   logic                      arvalid;
   logic                      arready;
   logic [`AXIL_DATA_W-1:0]   rdata;
   axil_resp_t                rresp;
   logic                      rvalid;
   logic                      rready;
   sample_t                   wave_sample;
   sample_t                   mod_sample;
   logic                      prbs_bit;

   // shadow of the control registers, as written over the bus
   logic                     cfg_run;
   logic [1:0]               cfg_wave_sel;
   logic [1:0]               cfg_mod_sel;
   phase_t                   cfg_car_inc;
   phase_t                   cfg_fsk_inc;
   logic [`DDS_PERIOD_W-1:0] cfg_period;

   // reference model state
   logic [`DDS_SAMPLE_W-1:0] sine_table [0:(1<<`DDS_LUT_AW)-1];
   phase_t                   m_phase_c;
   phase_t                   m_phase_f;
   sample_t                  m_sin;
   sample_t                  m_cos;
   sample_t                  m_saw;
   sample_t                  m_squ;
   sample_t                  m_fcos;
   sample_t                  m_wave;
   sample_t                  m_mod;
   logic [`DDS_LFSR_W-1:0]   m_lfsr;
   logic [`DDS_LFSR_W-1:0]   m_status_rd;   // lfsr seen by the last status read
   logic [`DDS_PERIOD_W-1:0] m_count;
   logic                     m_bit_d;
   logic                     m_prbs;
   int                       m_period_eff;

   int    errors = 0;
   int    checks = 0;
   int    cycle_count = 0;
   logic  compare_en = 1'b0;
   string test_name = "reset";

   dds_mod_top dds_mod_top_inst (.*);

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // helpers

   function automatic sample_t sine_from_phase(input phase_t p);
      logic [3:0] i;
      sample_t    s;
      i = p[29:26];
      case (p[31:30])
         2'd0:    s = sample_t'(sine_table[i]);
         2'd1:    s = sample_t'(sine_table[4'd15 - i]);     // falling side
         2'd2:    s = -sample_t'(sine_table[i]);
         default: s = -sample_t'(sine_table[4'd15 - i]);
      endcase
      return s;
   endfunction

   function automatic logic [31:0] ctrl_word(input logic run, input logic [1:0] wave,
                                             input logic [1:0] mod);
      return {27'd0, mod, wave, run};
   endfunction

   function automatic logic [31:0] random_inc();
      logic [31:0] raw;
      raw = $urandom;
      return raw >> ($urandom % 12);   // spread of slow and fast carriers
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (expected !== actual)
      begin
         errors++;
         $display("FAIL %s / %s: expected %h, actual %h at %0t",
                  test_name, name, expected, actual, $time);
      end
   endtask

   task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                             output axil_resp_t resp);
      @(posedge clk);
      #1;
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      do
         @(negedge clk);
      while (!awready);      // taken on the coming edge
      check_value("wready with awready", 32'd1, 32'(wready));
      @(posedge clk);
      #1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      while (!bvalid)
         @(negedge clk);
      resp = bresp;
      @(posedge clk);
      #1;
      bready = 1'b0;
   endtask

   task automatic axil_read(input logic [4:0] addr, output logic [31:0] data,
                            output axil_resp_t resp);
      @(posedge clk);
      #1;
      araddr  = addr;
      arvalid = 1'b1;
      do
         @(negedge clk);
      while (!arready);
      @(posedge clk);
      #1;
      arvalid = 1'b0;
      rready  = 1'b1;
      while (!rvalid)
         @(negedge clk);
      data = rdata;
      resp = rresp;
      @(posedge clk);
      #1;
      rready = 1'b0;
   endtask

   task automatic configure(input logic [31:0] car, input logic [31:0] fsk,
                            input logic [31:0] period, input logic [31:0] ctrl);
      axil_resp_t resp;
      axil_write(reg_carrier_inc, car, resp);
      axil_write(reg_fsk_inc, fsk, resp);
      axil_write(reg_bit_period, period, resp);
      axil_write(reg_ctrl, ctrl, resp);
      check_value("ctrl write resp", 32'(resp_okay), 32'(resp));
   endtask

   task automatic write_readback(input logic [4:0] addr, input logic [31:0] mask);
      logic [31:0] val;
      logic [31:0] rd;
      axil_resp_t  resp;
      val = $urandom;
      axil_write(addr, val, resp);
      check_value("write resp", 32'(resp_okay), 32'(resp));
      axil_read(addr, rd, resp);
      check_value("read resp", 32'(resp_okay), 32'(resp));
      check_value($sformatf("readback of %h", addr), val & mask, rd);
   endtask

   //////////////////////////////////////////////////////////////////////
   // cycle model, register writes land on the edge that raises bvalid

   assign m_period_eff = (cfg_period == '0) ? 1 : int'(cfg_period);

   always @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         cfg_run      <= 1'b0;
         cfg_wave_sel <= 2'd0;
         cfg_mod_sel  <= 2'd0;
         cfg_car_inc  <= '0;
         cfg_fsk_inc  <= '0;
         cfg_period   <= 16'd100;
         m_phase_c    <= '0;
         m_phase_f    <= '0;
         m_sin        <= '0;
         m_cos        <= '0;
         m_saw        <= '0;
         m_squ        <= '0;
         m_fcos       <= '0;
         m_wave       <= '0;
         m_mod        <= '0;
         m_lfsr       <= '1;
         m_status_rd  <= '0;
         m_count      <= '0;
         m_bit_d      <= 1'b0;
         m_prbs       <= 1'b0;
      end
      else
      begin
         if (awvalid && wvalid && awready)
         begin
            case (awaddr)
               reg_ctrl:
               begin
                  cfg_run      <= wdata[0];
                  cfg_wave_sel <= wdata[2:1];
                  cfg_mod_sel  <= wdata[4:3];
               end
               reg_carrier_inc: cfg_car_inc <= wdata;
               reg_fsk_inc:     cfg_fsk_inc <= wdata;
               reg_bit_period:  cfg_period <= wdata[15:0];
               default: ;
            endcase
         end
         if (arvalid && arready)
            m_status_rd <= m_lfsr;
         if (cfg_run)
         begin
            m_phase_c <= m_phase_c + cfg_car_inc;
            m_phase_f <= m_phase_f + cfg_fsk_inc;
            if (int'(m_count) + 1 >= m_period_eff)     // end of a bit period
            begin
               m_count <= '0;
               m_lfsr  <= {m_lfsr[0] ^ m_lfsr[2], m_lfsr[4:1]};
            end
            else
               m_count <= m_count + 16'd1;
         end
         m_sin   <= sine_from_phase(m_phase_c);
         m_cos   <= sine_from_phase(m_phase_c + quarter_turn);
         m_saw   <= sample_t'(m_phase_c[31:20]);
         m_squ   <= m_phase_c[31] ? sample_t'(-2047) : sample_t'(2047);
         m_fcos  <= sine_from_phase(m_phase_f + quarter_turn);
         m_bit_d <= m_lfsr[0];
         m_prbs  <= m_bit_d;
         case (cfg_wave_sel)
            2'd0:    m_wave <= m_sin;
            2'd1:    m_wave <= m_cos;
            2'd2:    m_wave <= m_saw;
            default: m_wave <= m_squ;
         endcase
         case (cfg_mod_sel)
            2'd0:    m_mod <= m_bit_d ? m_cos : sample_t'(0);
            2'd1:    m_mod <= m_bit_d ? m_fcos : m_cos;
            2'd2:    m_mod <= m_bit_d ? m_cos : -m_cos;
            default: m_mod <= m_bit_d ? sample_t'(2047) : sample_t'(-2048);
         endcase
      end
   end

   // outputs are compared mid cycle
   always @(negedge clk)
   begin
      if (compare_en)
      begin
         check_value("wave_sample", 32'(m_wave), 32'(wave_sample));
         check_value("mod_sample", 32'(m_mod), 32'(mod_sample));
         check_value("prbs_bit", 32'(m_prbs), 32'(prbs_bit));
      end
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("timeout: tests still running after %0d cycles", cycle_limit);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // tests

   task automatic register_test();
      logic [31:0] rd;
      logic [4:0]  bad_addr;
      axil_resp_t  resp;
      test_name = "registers";
      axil_read(reg_ctrl, rd, resp);
      check_value("ctrl after reset", 32'd0, rd);
      axil_read(reg_carrier_inc, rd, resp);
      check_value("carrier_inc after reset", 32'd0, rd);
      axil_read(reg_fsk_inc, rd, resp);
      check_value("fsk_inc after reset", 32'd0, rd);
      axil_read(reg_bit_period, rd, resp);
      check_value("bit_period after reset", 32'd100, rd);
      axil_read(reg_status, rd, resp);
      check_value("status after reset", 32'h1f, rd);
      repeat (6)
      begin
         write_readback(reg_ctrl, 32'h1f);
         write_readback(reg_carrier_inc, 32'hffff_ffff);
         write_readback(reg_fsk_inc, 32'hffff_ffff);
         write_readback(reg_bit_period, 32'h0000_ffff);
      end
      axil_write(reg_ctrl, 32'd0, resp);    // stop, lfsr holds
      axil_read(reg_status, rd, resp);
      check_value("status value", 32'(m_status_rd), rd);
      axil_write(reg_status, $urandom, resp);
      check_value("status write resp", 32'(resp_okay), 32'(resp));
      axil_read(reg_status, rd, resp);
      check_value("status after write", 32'(m_status_rd), rd);
      bad_addr = 5'h14 + 5'($urandom % 12);
      axil_write(bad_addr, $urandom, resp);
      check_value("unmapped write resp", 32'(resp_slverr), 32'(resp));
      axil_read(bad_addr, rd, resp);
      check_value("unmapped read resp", 32'(resp_slverr), 32'(resp));
      check_value("unmapped read data", 32'd0, rd);
   endtask

   task automatic waveform_test();
      for (int w = 0; w < 4; w++)
      begin
         test_name = $sformatf("waveform %0d", w);
         configure(random_inc(), 32'd0, 32'd100, ctrl_word(1'b1, 2'(w), mod_ask));
         repeat (wave_len) @(posedge clk);
      end
   endtask

   task automatic prbs_test();
      logic [31:0] period;
      logic [31:0] rd;
      axil_resp_t  resp;
      for (int r = 0; r < prbs_rounds; r++)
      begin
         period    = 32'd2 + ($urandom % 19);
         test_name = $sformatf("prbs period %0d", period);
         configure(random_inc(), random_inc(), period,
                   ctrl_word(1'b1, wave_square, mod_prbs));
         repeat (8)
         begin
            repeat (prbs_len / 8) @(posedge clk);
            axil_read(reg_status, rd, resp);
            check_value("status lfsr", 32'(m_status_rd), rd);
         end
      end
   endtask

   task automatic modulation_test();
      logic [31:0] period;
      for (int m = 0; m < 3; m++)
      begin
         period    = 32'd2 + ($urandom % 6);
         test_name = $sformatf("modulation %0d", m);
         configure(random_inc(), random_inc(), period,
                   ctrl_word(1'b1, 2'($urandom % 4), 2'(m)));
         repeat (mod_len) @(posedge clk);
      end
   endtask

   task automatic run_hold_test();
      sample_t    wave_hold;
      sample_t    mod_hold;
      logic       bit_hold;
      axil_resp_t resp;
      test_name = "run hold";
      configure(random_inc(), random_inc(), 32'd3, ctrl_word(1'b1, wave_saw, mod_bpsk));
      repeat (hold_len) @(posedge clk);
      axil_write(reg_ctrl, ctrl_word(1'b0, wave_saw, mod_bpsk), resp);
      repeat (2) @(posedge clk);   // two stage pipeline drains
      @(negedge clk);
      wave_hold = m_wave;
      mod_hold  = m_mod;
      bit_hold  = m_prbs;
      repeat (hold_len)
      begin
         @(negedge clk);
         check_value("frozen wave_sample", 32'(wave_hold), 32'(wave_sample));
         check_value("frozen mod_sample", 32'(mod_hold), 32'(mod_sample));
         check_value("frozen prbs_bit", 32'(bit_hold), 32'(prbs_bit));
      end
      axil_write(reg_ctrl, ctrl_word(1'b1, wave_saw, mod_bpsk), resp);
      repeat (hold_len) @(posedge clk);
   endtask

   initial
   begin
      void'($urandom(32'h05bcd914));
      $readmemh("sine_quarter.hex", sine_table);
      reset   = 1'b1;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '1;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      reset      = 1'b0;
      compare_en = 1'b1;
      register_test();
      waveform_test();
      prbs_test();
      modulation_test();
      run_hold_test();
      repeat (4) @(posedge clk);
      $display("tests done: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// ==== sine_quarter.hex ====
// first quadrant sine magnitudes, one 12-bit hex value per line
// line n holds round(2047 * sin((2n+1) * pi / 64)) for n = 0 to 15
064
12C
1F1
2B2
36B
41C
4C3
55F
5ED
66C
6DC
73A
787
7C2
7E9
7FD

// ==== sources.f ====
+incdir+src
src/dds_pkg.sv
src/axil_pkg.sv
src/dds_ctrl_if.sv
src/axil_regs.sv
src/dds_waveform.sv
src/prbs_bit_source.sv
src/modulator.sv
src/dds_mod_top.sv
testbench/tb_dds_mod.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_dds_mod -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "PASS: all tests" sim.log; then
   exit 0
fi
exit 1
